// ==== common/fetch_if.sv ====
// link between the IF stage and the prefetch buffer
// a branch pulse flushes the buffer, branch_addr must be halfword aligned
// rdata holds a 32-bit instr or a compressed one in its low half
`timescale 1ns/1ps

interface fetch_if import fetch_pkg::*; ();

  logic              branch;       // restart fetch, one cycle pulse
  logic [BUS_AW-1:0] branch_addr;
  logic              ready;        // stage takes the instr
  logic              valid;
  logic [31:0]       rdata;
  logic [BUS_AW-1:0] addr;         // pc of rdata
  logic              err;          // bus error on any word used

  modport stage (
    output branch, branch_addr, ready,
    input  valid, rdata, addr, err
  );

  modport buffer (
    input  branch, branch_addr, ready,
    output valid, rdata, addr, err
  );

endinterface

// ==== common/fetch_pkg.sv ====
// shared types and constants of the instruction fetch subsystem
// exc_cause_e lists only the causes the fetch path has to tell apart
// the bus is 32 bits wide, at most one request outstanding
package fetch_pkg;

  //////////////////////////////////////////////////
  // bus geometry and boot
  localparam int unsigned BUS_AW = 32;  // instr address width
  localparam int unsigned BUS_DW = 32;  // instr data width

  localparam logic [31:0] BOOT_OFFSET = 32'h0000_0080;  // first fetch past boot_addr

  //////////////////////////////////////////////////
  // pc and handler selects
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,  // back to mepc
    PC_DRET = 3'd4   // back to depc
  } pc_sel_e;

  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,  // mtvec base
    EXC_PC_IRQ     = 2'd1,  // vectored irq entry
    EXC_PC_DBD     = 2'd2,  // debug halt
    EXC_PC_DBG_EXC = 2'd3   // exception while in debug mode
  } exc_pc_sel_e;

  // msb set for interrupts, [4:0] is the irq id
  typedef enum logic [5:0] {
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'b1_00011,
    EXC_CAUSE_IRQ_TIMER_M        = 6'b1_00111,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'b1_01011,
    EXC_CAUSE_IRQ_FAST_0         = 6'b1_10000,
    EXC_CAUSE_IRQ_NM             = 6'b1_11111,
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'b0_00001,
    EXC_CAUSE_ILLEGAL_INSN       = 6'b0_00010,
    EXC_CAUSE_BREAKPOINT         = 6'b0_00011,
    EXC_CAUSE_ECALL_MMODE        = 6'b0_01011
  } exc_cause_e;

  // rv32i major opcodes produced by the rvc expander
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // one fetched word, whole or as two halves
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] hi;  // upper halfword, pc+2
      logic [15:0] lo;  // lower halfword
    } half;
  } fetch_word_u;

endpackage

// ==== fetch/fetch_compressed_decoder.sv ====
// rvc expander for c.addi/c.nop, c.li, c.lui, c.mv, c.add, c.lw, c.sw and c.j
// every other compressed encoding is flagged illegal, instr_o is then don't-care
// 32-bit instructions pass through unchanged
`timescale 1ns/1ps

module fetch_compressed_decoder import fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        valid_i,
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_instr_o
);

  logic [15:0] c;      // the compressed half
  logic [4:0]  rd;     // full rd / rs1 field
  logic [4:0]  rs2;    // full rs2 field
  logic [4:0]  rd_p;   // rd' / rs2', x8..x15
  logic [4:0]  rs1_p;  // rs1', x8..x15
  logic [11:0] imm6;   // sign extended 6 bit imm

  assign c     = instr_i[15:0];
  assign rd    = c[11:7];
  assign rs2   = c[6:2];
  assign rd_p  = {2'b01, c[4:2]};
  assign rs1_p = {2'b01, c[9:7]};
  assign imm6  = {{6{c[12]}}, c[12], c[6:2]};

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o         = is_compressed_o ? {16'h0000, c} : instr_i;
    illegal_instr_o = 1'b0;

    case (c[1:0])
      // quadrant 0
      2'b00: begin
        case (c[15:13])
          3'b010: begin  // c.lw, zero extended word offset
            instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010, rd_p, OPC_LOAD};
          end
          3'b110: begin  // c.sw
            instr_o = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010,
                       c[11:10], c[6], 2'b00, OPC_STORE};
          end
          default: illegal_instr_o = 1'b1;  // c.addi4spn, fp ops, reserved
        endcase
      end

      // quadrant 1
      2'b01: begin
        case (c[15:13])
          3'b000: instr_o = {imm6, rd, 3'b000, rd, OPC_OP_IMM};    // c.addi, c.nop
          3'b010: instr_o = {imm6, 5'd0, 3'b000, rd, OPC_OP_IMM};  // c.li
          3'b011: begin
            instr_o = {{15{c[12]}}, c[6:2], rd, OPC_LUI};
            // rd=x2 is c.addi16sp, not supported
            // zero imm is reserved
            if (rd == 5'd2 || {c[12], c[6:2]} == 6'd0) begin
              illegal_instr_o = 1'b1;
            end
          end
          3'b101: begin  // c.j, jal x0
            instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       {9{c[12]}}, 5'd0, OPC_JAL};
          end
          default: illegal_instr_o = 1'b1;  // c.jal, alu ops, branches
        endcase
      end

      // quadrant 2
      2'b10: begin
        if (c[15:13] == 3'b100 && rs2 != 5'd0) begin
          // c.mv with bit 12 clear, c.add with it set
          instr_o = {7'b0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, OPC_OP};
        end else begin
          illegal_instr_o = 1'b1;  // c.jr, c.jalr, c.ebreak, sp loads and stores
        end
      end

      default: ;  // 32-bit, pass through
    endcase
  end

  //////////////////////////////////////////////////
  // assertions

  // upper half only matters for a 32-bit instr
  a_instr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> !$isunknown(c) && (is_compressed_o || !$isunknown(instr_i[31:16])))
    else $error("unknown instr while valid");

endmodule

// ==== fetch/fetch_if_stage.sv ====
// IF stage: next-pc and handler muxes, prefetch buffer, rvc expander, IF-ID regs
// boot_addr_i must be 256 byte aligned, its low byte is ignored
// the first req_i after reset forces a fetch from the current mux target
`timescale 1ns/1ps

module fetch_if_stage import fetch_pkg::*; #(
  parameter logic [31:0] DmHaltAddr      = 32'h1A11_0800,
  parameter logic [31:0] DmExceptionAddr = 32'h1A11_0808
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,                // fetch enable
  input  logic              pc_set_i,             // take the mux target
  input  logic              instr_valid_clear_i,
  input  logic              id_in_ready_i,        // decode can take an instr
  input  pc_sel_e           pc_mux_i,
  input  exc_pc_sel_e       exc_pc_mux_i,
  input  exc_cause_e        exc_cause_i,
  input  logic [31:0]       boot_addr_i,
  input  logic [31:0]       jump_target_i,
  input  logic [31:0]       csr_mepc_i,
  input  logic [31:0]       csr_depc_i,
  input  logic [31:0]       csr_mtvec_i,
  output logic              instr_req_o,
  output logic [BUS_AW-1:0] instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  logic [BUS_DW-1:0] instr_rdata_i,
  input  logic              instr_err_i,
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o,       // high the cycle after a load
  output logic [31:0]       instr_rdata_id_o,     // expanded instr
  output logic [15:0]       instr_rdata_c_id_o,   // raw half, for mtval
  output logic              instr_is_compressed_id_o,
  output logic              illegal_c_insn_id_o,
  output logic              instr_fetch_err_o,
  output logic [31:0]       pc_if_o,
  output logic [31:0]       pc_id_o,
  output logic              csr_mtvec_init_o,
  output logic              if_busy_o
);

  fetch_if     fif ();

  logic        offset_in_init_q, offset_in_init_d;  // nothing fetched since reset
  logic [31:0] exc_pc;
  logic [31:0] fetch_addr_n;
  logic        if_id_we;
  fetch_word_u fetch_word;
  logic [31:0] instr_expanded;
  logic        instr_is_compressed;
  logic        illegal_c_insn;

  //////////////////////////////////////////////////
  // target muxes
  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, exc_cause_i[4:0], 2'b00};
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = {csr_mtvec_i[31:8], 8'h00};  // direct mode base
    endcase
  end

  always_comb begin
    case (pc_mux_i)
      PC_JUMP: fetch_addr_n = jump_target_i;
      PC_EXC:  fetch_addr_n = exc_pc;
      PC_ERET: fetch_addr_n = csr_mepc_i;
      PC_DRET: fetch_addr_n = csr_depc_i;
      default: fetch_addr_n = {boot_addr_i[31:8], 8'h00} + BOOT_OFFSET;
    endcase
  end

  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);  // boot also sets mtvec

  //////////////////////////////////////////////////
  // fetch control
  assign fif.branch      = pc_set_i | (offset_in_init_q & req_i);
  assign fif.branch_addr = {fetch_addr_n[31:1], 1'b0};
  assign offset_in_init_d = offset_in_init_q & ~req_i & ~pc_set_i;

  assign if_id_we  = fif.valid & req_i & id_in_ready_i & ~pc_set_i & ~offset_in_init_q;
  assign fif.ready = if_id_we;  // consume exactly what is loaded

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_in_init_q <= 1'b1;
    end else begin
      offset_in_init_q <= offset_in_init_d;
    end
  end

  fetch_prefetch_buffer u_prefetch_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .fif            (fif.buffer),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (if_busy_o)
  );

  assign pc_if_o    = fif.addr;
  assign fetch_word = fif.rdata;

  fetch_compressed_decoder u_compressed_decoder (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .valid_i         (fif.valid),
    .instr_i         (fif.rdata),
    .instr_o         (instr_expanded),
    .is_compressed_o (instr_is_compressed),
    .illegal_instr_o (illegal_c_insn)
  );

  //////////////////////////////////////////////////
  // IF-ID registers, frozen while decode stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_new_id_o <= if_id_we;
      if (if_id_we) begin
        instr_valid_id_o <= 1'b1;
      end else if (instr_valid_clear_i) begin
        instr_valid_id_o <= 1'b0;  // load wins over clear
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (if_id_we) begin
      instr_rdata_id_o         <= instr_expanded;
      instr_rdata_c_id_o       <= fetch_word.half.lo;
      instr_is_compressed_id_o <= instr_is_compressed;
      illegal_c_insn_id_o      <= illegal_c_insn;
      instr_fetch_err_o        <= fif.err;
      pc_id_o                  <= pc_if_o;
    end
  end

  //////////////////////////////////////////////////
  // assertions

  a_pc_mux_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> pc_mux_i inside {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET, PC_DRET})
    else $error("illegal pc_mux_i");

  a_boot_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    boot_addr_i[7:0] == 8'h00)
    else $error("boot_addr_i not 256 byte aligned");

  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_err_i |-> instr_rvalid_i)
    else $error("instr_err_i without instr_rvalid_i");

  a_req_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o) && (instr_addr_o[1:0] == 2'b00))
    else $error("request addr unknown or not word aligned");

endmodule

// ==== fetch/fetch_prefetch_buffer.sv ====
// word fetcher with a two-entry queue and halfword realigner
// one request at a time, a request pending at a branch is finished and its data dropped
// so the first request after such a branch starts only once the bus is free
`timescale 1ns/1ps

module fetch_prefetch_buffer import fetch_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  fetch_if.buffer           fif,
  output logic              instr_req_o,
  output logic [BUS_AW-1:0] instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  logic [BUS_DW-1:0] instr_rdata_i,
  input  logic              instr_err_i,
  output logic              busy_o
);

  logic                   req_q, req_d;            // bus request up
  logic [BUS_AW-1:0]      req_addr_q, req_addr_d;
  logic                   outst_q, outst_d;        // granted, waiting for rvalid
  logic                   discard_q, discard_d;    // in-flight word is stale
  logic [BUS_AW-1:0]      fetch_addr_q, fetch_addr_d;  // next word to ask for
  logic [BUS_AW-1:0]      addr_q, addr_d;          // pc of the head instr
  logic [1:0]             count_q, count_d;        // words queued
  fetch_word_u [1:0]      word_q, word_d;          // [0] is the head
  logic [1:0]             err_q, err_d;

  fetch_word_u            head, next;
  logic                   head_c, straddle;
  logic                   consume, pop, push;
  logic                   hold, issue;
  logic [BUS_AW-1:0]      base;

  //////////////////////////////////////////////////
  // realigner
  assign head     = word_q[0];
  assign next     = word_q[1];
  assign head_c   = addr_q[1] ? (head.half.hi[1:0] != 2'b11)
                              : (head.half.lo[1:0] != 2'b11);
  assign straddle = addr_q[1] & ~head_c;  // 32-bit instr across two words

  assign fif.valid = straddle ? (count_q == 2'd2) : (count_q != 2'd0);
  assign fif.rdata = addr_q[1] ? {next.half.lo, head.half.hi} : head.word;
  assign fif.addr  = addr_q;
  assign fif.err   = err_q[0] | (straddle & err_q[1]);

  assign consume = fif.valid & fif.ready & ~fif.branch;
  assign pop     = consume & (addr_q[1] | ~head_c);  // head word used up
  assign push    = outst_q & instr_rvalid_i & ~discard_q & ~fif.branch;

  always_comb begin
    addr_d = addr_q;
    if (fif.branch) begin
      addr_d = fif.branch_addr;
    end else if (consume) begin
      addr_d = addr_q + (head_c ? 32'd2 : 32'd4);
    end
  end

  // shift out on pop, then append the response
  always_comb begin
    word_d  = word_q;
    err_d   = err_q;
    count_d = count_q;
    if (pop) begin
      word_d[0] = word_q[1];
      err_d[0]  = err_q[1];
      count_d   = count_d - 2'd1;
    end
    if (push) begin
      word_d[count_d[0]] = instr_rdata_i;
      err_d[count_d[0]]  = instr_err_i;
      count_d            = count_d + 2'd1;
    end
    if (fif.branch) count_d = 2'd0;  // flush
  end

  //////////////////////////////////////////////////
  // bus requester
  assign hold  = req_q & ~instr_gnt_i;  // addr must stay until grant
  assign base  = fif.branch ? {fif.branch_addr[BUS_AW-1:2], 2'b00} : fetch_addr_q;
  assign issue = ~req_q & ~(outst_q & ~instr_rvalid_i) & req_i & (count_d != 2'd2);

  assign req_d        = hold | issue;
  assign req_addr_d   = issue ? base : req_addr_q;
  assign fetch_addr_d = issue ? base + 32'd4 : base;
  assign outst_d      = (req_q & instr_gnt_i) | (outst_q & ~instr_rvalid_i);

  always_comb begin
    discard_d = discard_q;
    if (fif.branch && (req_q || (outst_q && !instr_rvalid_i))) begin
      discard_d = 1'b1;  // old stream still on the bus
    end else if (outst_q && instr_rvalid_i) begin
      discard_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q        <= 1'b0;
      outst_q      <= 1'b0;
      discard_q    <= 1'b0;
      count_q      <= 2'd0;
      addr_q       <= '0;
      fetch_addr_q <= '0;
    end else begin
      req_q        <= req_d;
      outst_q      <= outst_d;
      discard_q    <= discard_d;
      count_q      <= count_d;
      addr_q       <= addr_d;
      fetch_addr_q <= fetch_addr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    word_q     <= word_d;
    err_q      <= err_d;
    req_addr_q <= req_addr_d;
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;
  assign busy_o       = req_q | outst_q;

  //////////////////////////////////////////////////
  // assertions

  // room was checked when the word was requested, cycles earlier
  a_queue_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> (count_q != 2'd2) || pop)
    else $error("prefetch queue overflow");

  a_valid_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fif.valid |-> !$isunknown(fif.addr))
    else $error("fetch valid with unknown addr");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_fetch_top -Mdir obj_dir -o sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// ==== tb.f ====
common/fetch_pkg.sv
common/fetch_if.sv
fetch/fetch_prefetch_buffer.sv
fetch/fetch_compressed_decoder.sv
fetch/fetch_if_stage.sv
verilog/fetch_top.sv
testbench/tb_fetch_top.sv

// ==== testbench/tb_fetch_top.sv ====
// directed testbench for fetch_top, bus memory model with random grant and response delays
// unwritten memory reads back a 32-bit fill word built from its address
// expected instrs come from a local rvc model and a model pc
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

  localparam int MAX_CYCLES = 3000;  // 6 tests, ~400 cycles each, plus margin
  localparam logic [31:0] DM_HALT = 32'h1A11_0800;
  localparam logic [31:0] DM_EXC  = 32'h1A11_0808;

  logic clk_i, rst_ni;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic instr_valid_id_o, instr_new_id_o, instr_is_compressed_id_o;
  logic illegal_c_insn_id_o, instr_fetch_err_o;
  logic [31:0] instr_rdata_id_o, pc_if_o, pc_id_o;
  logic [15:0] instr_rdata_c_id_o;
  logic req_i, pc_set_i, instr_valid_clear_i, id_in_ready_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  exc_cause_e  exc_cause_i;
  logic [31:0] jump_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i, boot_addr_i;
  logic csr_mtvec_init_o, if_busy_o;

  logic [31:0] img [logic [31:0]];  // program image, word addressed
  logic [31:0] err_addr;            // word that answers with a bus error
  logic [31:0] model_pc;
  int cycle_cnt, test_errs, total_errs, failed_tests;

  fetch_top #(.DmHaltAddr(DM_HALT), .DmExceptionAddr(DM_EXC)) UUT (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;  // 100 ns period

  //////////////////////////////////////////////////
  // memory image
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    if (img.exists(wa)) return img[wa];
    return {wa[31:2], 2'b11};  // fill, always a 32-bit opcode
  endfunction

  function automatic logic [15:0] mem_half(input logic [31:0] a);
    logic [31:0] w;
    w = mem_word(a);
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic void put_half(input logic [31:0] a, input logic [15:0] h);
    logic [31:0] wa;
    logic [31:0] w;
    wa = {a[31:2], 2'b00};
    w  = mem_word(wa);
    if (a[1]) w[31:16] = h;
    else w[15:0] = h;
    img[wa] = w;
  endfunction

  //////////////////////////////////////////////////
  // rvc reference, returns {illegal, instr}
  function automatic logic [32:0] expand_rvc(input logic [15:0] c);
    logic [31:0] imm;
    logic [4:0]  rd, rs2, rdp, rs1p;
    logic [11:0] off;
    logic [20:0] j;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = {2'b01, c[4:2]};
    rs1p = {2'b01, c[9:7]};
    imm  = {{26{c[12]}}, c[12], c[6:2]};
    off  = {5'd0, c[5], c[12:10], c[6], 2'b00};  // lw/sw word offset
    j    = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    case ({c[15:13], c[1:0]})
      5'b010_00: return {1'b0, off, rs1p, 3'b010, rdp, 7'h03};
      5'b110_00: return {1'b0, off[11:5], rdp, rs1p, 3'b010, off[4:0], 7'h23};
      5'b000_01: return {1'b0, imm[11:0], rd, 3'b000, rd, 7'h13};
      5'b010_01: return {1'b0, imm[11:0], 5'd0, 3'b000, rd, 7'h13};
      5'b011_01: return {(rd == 5'd2) || (imm == 32'd0), imm[19:0], rd, 7'h37};
      5'b101_01: return {1'b0, j[20], j[10:1], j[11], j[19:12], 5'd0, 7'h6f};
      5'b100_10: begin
        if (rs2 == 5'd0) return {1'b1, 32'd0};  // jr, jalr, ebreak
        return {1'b0, 7'd0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, 7'h33};
      end
      default: return {1'b1, 32'd0};
    endcase
  endfunction

  //////////////////////////////////////////////////
  // bus memory model
  initial begin : bus_model
    logic [31:0] a;
    int d;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    void'($urandom(27621));
    forever begin
      @(posedge clk_i);
      #1;
      instr_rvalid_i = 1'b0;
      instr_err_i    = 1'b0;
      if (rst_ni && instr_req_o) begin
        d = $urandom_range(3, 0);  // grant delay
        repeat (d) begin
          @(posedge clk_i);
          #1;
        end
        a = instr_addr_o;
        instr_gnt_i = 1'b1;
        @(posedge clk_i);
        #1;
        instr_gnt_i = 1'b0;
        d = $urandom_range(3, 0);  // response delay after the grant cycle
        repeat (d) begin
          @(posedge clk_i);
          #1;
        end
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = mem_word(a);
        instr_err_i    = (a == err_addr);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  task automatic tick();
    @(posedge clk_i);
    #1;  // drive and sample just after the edge
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      test_errs++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic redirect(input pc_sel_e sel, input logic [31:0] start);
    pc_set_i = 1'b1;
    pc_mux_i = sel;
    tick();
    pc_set_i = 1'b0;
    model_pc = start;
  endtask

  // waits for n decode loads, each checked against the model pc
  task automatic run_stream(input int n);
    int got;
    logic [15:0] lo;
    logic [31:0] exp_instr;
    logic [32:0] x;
    logic comp, bad;
    got = 0;
    while (got < n) begin
      tick();
      if (instr_new_id_o) begin
        lo   = mem_half(model_pc);
        comp = (lo[1:0] != 2'b11);
        x    = expand_rvc(lo);
        exp_instr = comp ? x[31:0] : {mem_half(model_pc + 32'd2), lo};
        bad = ({model_pc[31:2], 2'b00} == err_addr) ||
              (!comp && model_pc[1] && ({model_pc[31:2], 2'b00} + 32'd4 == err_addr));
        check(pc_id_o, model_pc, "pc_id_o");
        check(32'(instr_valid_id_o), 32'd1, "instr_valid_id_o");
        check(32'(instr_is_compressed_id_o), 32'(comp), "instr_is_compressed_id_o");
        check(32'(illegal_c_insn_id_o), comp ? 32'(x[32]) : 32'd0, "illegal_c_insn_id_o");
        check(32'(instr_rdata_c_id_o), 32'(lo), "instr_rdata_c_id_o");
        check(32'(instr_fetch_err_o), 32'(bad), "instr_fetch_err_o");
        if (!(comp && x[32])) check(instr_rdata_id_o, exp_instr, "instr_rdata_id_o");
        model_pc = model_pc + (comp ? 32'd2 : 32'd4);
        check(pc_if_o, model_pc, "pc_if_o");  // fetch side moved to the next instr
        got++;
      end
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-14s %s, %0d errors", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    total_errs += test_errs;
    if (test_errs != 0) failed_tests++;
    test_errs = 0;
  endtask

  //////////////////////////////////////////////////
  // tests
  task automatic test_boot();
    for (int k = 0; k < 6; k++) begin
      img[32'h1080 + 32'(4 * k)] = {12'(k + 1), 5'd0, 3'b000, 5'(k + 1), 7'h13};
    end
    // state straight out of reset
    check(32'(instr_req_o), 32'd0, "instr_req_o after reset");
    check(32'(instr_valid_id_o), 32'd0, "instr_valid_id_o after reset");
    check(32'(instr_new_id_o), 32'd0, "instr_new_id_o after reset");
    check(32'(csr_mtvec_init_o), 32'd0, "csr_mtvec_init_o after reset");
    check(32'(if_busy_o), 32'd0, "if_busy_o after reset");
    model_pc = boot_addr_i + 32'h80;
    req_i    = 1'b1;
    pc_set_i = 1'b1;
    pc_mux_i = PC_BOOT;
    #1;
    check(32'(csr_mtvec_init_o), 32'd1, "csr_mtvec_init_o in boot cycle");
    tick();
    pc_set_i = 1'b0;
    #1;
    check(32'(csr_mtvec_init_o), 32'd0, "csr_mtvec_init_o after boot cycle");
    // idle bus, so the request follows the branch at once
    check(32'(instr_req_o), 32'd1, "instr_req_o after boot branch");
    check(instr_addr_o, {model_pc[31:2], 2'b00}, "instr_addr_o after boot branch");
    check(32'(if_busy_o), 32'd1, "if_busy_o after boot branch");
    check(pc_if_o, model_pc, "pc_if_o after boot branch");
    run_stream(6);
    end_test("boot");
  endtask

  // c.addi c.nop c.li c.lui c.mv c.add c.lw c.sw c.j, then three illegal ones
  task automatic load_rvc_program();
    logic [15:0] prog [12];
    prog = '{16'h0095, 16'h0001, 16'h5175, 16'h6185, 16'h8216, 16'h931E,
             16'h4144, 16'hC60C, 16'hA801, 16'h0000, 16'h6181, 16'h8082};
    for (int k = 0; k < 12; k++) put_half(32'h1200 + 32'(2 * k), prog[k]);
  endtask

  task automatic test_rvc();
    load_rvc_program();
    jump_target_i = 32'h1200;
    redirect(PC_JUMP, 32'h1200);
    run_stream(12);
    end_test("rvc_expand");
  endtask

  task automatic test_realign();
    logic [15:0] prog [10];
    prog = '{16'h0001, 16'h0093, 16'h0010, 16'h5175, 16'h0113,
             16'h00A0, 16'h8216, 16'h5037, 16'h1234, 16'h0095};
    for (int k = 0; k < 10; k++) put_half(32'h1400 + 32'(2 * k), prog[k]);
    jump_target_i = 32'h1402;  // starts in an upper half, straddling 32-bit
    redirect(PC_JUMP, 32'h1402);
    run_stream(7);
    end_test("realign_jump");
  endtask

  task automatic test_traps();
    logic [31:0] base;
    base = csr_mtvec_i & ~32'hFF;
    exc_pc_mux_i = EXC_PC_EXC;
    redirect(PC_EXC, base);
    run_stream(2);
    exc_pc_mux_i = EXC_PC_IRQ;
    exc_cause_i  = EXC_CAUSE_IRQ_TIMER_M;  // id 7
    redirect(PC_EXC, base + 32'd28);
    run_stream(2);
    exc_pc_mux_i = EXC_PC_DBD;
    redirect(PC_EXC, DM_HALT);
    run_stream(2);
    exc_pc_mux_i = EXC_PC_DBG_EXC;
    redirect(PC_EXC, DM_EXC);
    run_stream(2);
    redirect(PC_ERET, csr_mepc_i);
    run_stream(2);
    redirect(PC_DRET, csr_depc_i);
    run_stream(2);
    end_test("trap_targets");
  endtask

  task automatic test_stall();
    logic [31:0] s_pc;
    logic [15:0] s_c;
    logic [32:0] x;
    jump_target_i = 32'h1200;
    redirect(PC_JUMP, 32'h1200);
    run_stream(3);
    id_in_ready_i = 1'b0;
    s_pc = model_pc - 32'd2;  // third instr of the rvc program, c.li
    s_c  = mem_half(s_pc);
    x    = expand_rvc(s_c);
    repeat (8) begin
      tick();
      check(pc_id_o, s_pc, "pc_id_o while stalled");
      check(instr_rdata_id_o, x[31:0], "instr_rdata_id_o while stalled");
      check(32'(instr_rdata_c_id_o), 32'(s_c), "raw half while stalled");
      check(32'(instr_is_compressed_id_o), 32'd1, "compressed flag while stalled");
      check(32'(illegal_c_insn_id_o), 32'(x[32]), "illegal flag while stalled");
      check(32'(instr_fetch_err_o), 32'd0, "fetch error while stalled");
      check(32'(instr_valid_id_o), 32'd1, "instr_valid_id_o while stalled");
      check(32'(instr_new_id_o), 32'd0, "instr_new_id_o while stalled");
    end
    instr_valid_clear_i = 1'b1;
    tick();
    instr_valid_clear_i = 1'b0;
    check(32'(instr_valid_id_o), 32'd0, "instr_valid_id_o after clear");
    id_in_ready_i = 1'b1;
    run_stream(5);  // no instr lost or repeated
    end_test("stall_clear");
  endtask

  task automatic test_bus_err();
    err_addr      = 32'h1604;
    jump_target_i = 32'h1600;
    redirect(PC_JUMP, 32'h1600);
    run_stream(4);
    err_addr = 32'hFFFF_FFFC;
    end_test("bus_error");
  endtask

  initial begin
    cycle_cnt = 0;
    test_errs = 0;
    total_errs = 0;
    failed_tests = 0;
    err_addr = 32'hFFFF_FFFC;  // nothing marked yet
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    exc_cause_i = EXC_CAUSE_IRQ_TIMER_M;
    jump_target_i = 32'h1200;
    csr_mepc_i = 32'h3004;
    csr_depc_i = 32'h3102;
    csr_mtvec_i = 32'h2001;  // mode bit set, must be masked off
    boot_addr_i = 32'h1000;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    tick();
    test_boot();
    test_rvc();
    test_realign();
    test_traps();
    test_stall();
    test_bus_err();
    $display("tests run: 6, failed: %0d, check errors: %0d", failed_tests, total_errs);
    if (total_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog/fetch_top.sv ====
// top of the fetch subsystem, plain ports only
// debug module addresses are set here and passed down
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter logic [31:0] DmHaltAddr      = 32'h1A11_0800,
  parameter logic [31:0] DmExceptionAddr = 32'h1A11_0808
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // instruction bus
  output logic              instr_req_o,
  output logic [BUS_AW-1:0] instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  logic [BUS_DW-1:0] instr_rdata_i,
  input  logic              instr_err_i,
  // to decode
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o,
  output logic [31:0]       instr_rdata_id_o,
  output logic [15:0]       instr_rdata_c_id_o,
  output logic              instr_is_compressed_id_o,
  output logic              illegal_c_insn_id_o,
  output logic              instr_fetch_err_o,
  output logic [31:0]       pc_if_o,
  output logic [31:0]       pc_id_o,
  // control
  input  logic              req_i,
  input  logic              pc_set_i,
  input  pc_sel_e           pc_mux_i,
  input  exc_pc_sel_e       exc_pc_mux_i,
  input  exc_cause_e        exc_cause_i,
  input  logic [31:0]       jump_target_i,
  input  logic [31:0]       csr_mepc_i,
  input  logic [31:0]       csr_depc_i,
  input  logic [31:0]       csr_mtvec_i,
  input  logic [31:0]       boot_addr_i,
  input  logic              instr_valid_clear_i,
  input  logic              id_in_ready_i,
  output logic              csr_mtvec_init_o,
  output logic              if_busy_o
);

  fetch_if_stage #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_if_stage (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .req_i                    (req_i),
    .pc_set_i                 (pc_set_i),
    .instr_valid_clear_i      (instr_valid_clear_i),
    .id_in_ready_i            (id_in_ready_i),
    .pc_mux_i                 (pc_mux_i),
    .exc_pc_mux_i             (exc_pc_mux_i),
    .exc_cause_i              (exc_cause_i),
    .boot_addr_i              (boot_addr_i),
    .jump_target_i            (jump_target_i),
    .csr_mepc_i               (csr_mepc_i),
    .csr_depc_i               (csr_depc_i),
    .csr_mtvec_i              (csr_mtvec_i),
    .instr_req_o              (instr_req_o),
    .instr_addr_o             (instr_addr_o),
    .instr_gnt_i              (instr_gnt_i),
    .instr_rvalid_i           (instr_rvalid_i),
    .instr_rdata_i            (instr_rdata_i),
    .instr_err_i              (instr_err_i),
    .instr_valid_id_o         (instr_valid_id_o),
    .instr_new_id_o           (instr_new_id_o),
    .instr_rdata_id_o         (instr_rdata_id_o),
    .instr_rdata_c_id_o       (instr_rdata_c_id_o),
    .instr_is_compressed_id_o (instr_is_compressed_id_o),
    .illegal_c_insn_id_o      (illegal_c_insn_id_o),
    .instr_fetch_err_o        (instr_fetch_err_o),
    .pc_if_o                  (pc_if_o),
    .pc_id_o                  (pc_id_o),
    .csr_mtvec_init_o         (csr_mtvec_init_o),
    .if_busy_o                (if_busy_o)
  );

endmodule
